/* src/noc_defines.svh */
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// mesh dimensions, columns by rows
`define MESH_NX 4
`define MESH_NY 4

// address field widths, derived from mesh size
`define MESH_XW $clog2(`MESH_NX)  // x address bits
`define MESH_YW $clog2(`MESH_NY)  // y address bits

// a mesh router always has local plus four neighbours
`define MESH_PORTS 5

`endif

/* src/routing_pkg.sv */
`default_nettype none

`include "noc_defines.svh"

package routing_pkg;

    // router port index, also the bit position in port_set_t
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,  // towards smaller y
        WEST  = 3'd3,
        SOUTH = 3'd4   // towards larger y
    } port_e;

    // run-time routing algorithm select
    typedef enum logic [2:0] {
        XY             = 3'd0,  // deterministic, x first
        WEST_FIRST     = 3'd1,
        NORTH_LAST     = 3'd2,
        NEGATIVE_FIRST = 3'd3,
        DUATO          = 3'd4,  // fully adaptive minimal
        ODD_EVEN       = 3'd5
    } route_mode_e;

    // one allow bit per output port
    typedef logic [`MESH_PORTS-1:0] port_set_t;

    // 4-bit destination code as seen by the port allocator
    typedef struct packed {
        logic dx;     // destination lies east
        logic dy;     // destination lies north
        logic use_x;  // an x port is allowed
        logic use_y;  // a y port is allowed
    } dest_code_t;

endpackage

`default_nettype wire

/* src/mesh_dir_if.sv */
`default_nettype none

// direction flags from the shared address comparator
interface mesh_dir_if;
    logic x_plus;  // dest east of current
    logic x_min;   // dest west of current
    logic y_plus;  // dest south
    logic y_min;   // dest north
    logic same_x;
    logic same_y;

    modport producer (
        output x_plus, x_min, y_plus, y_min, same_x, same_y
    );

    modport consumer (
        input x_plus, x_min, y_plus, y_min, same_x, same_y
    );
endinterface

`default_nettype wire

/* src/mesh_dir.sv */
`default_nettype none

`include "noc_defines.svh"

// unsigned compare of current vs destination address, per dimension
module mesh_dir (
    input  logic [`MESH_XW-1:0] current_x,
    input  logic [`MESH_YW-1:0] current_y,
    input  logic [`MESH_XW-1:0] dest_x,
    input  logic [`MESH_YW-1:0] dest_y,
    mesh_dir_if.producer        dir
);

    // x dimension
    assign dir.x_plus = (dest_x > current_x);   // go east
    assign dir.x_min  = (dest_x < current_x);   // go west
    assign dir.same_x = (dest_x == current_x);

    // y dimension, north is the smaller y
    assign dir.y_plus = (dest_y > current_y);   // go south
    assign dir.y_min  = (dest_y < current_y);   // go north
    assign dir.same_y = (dest_y == current_y);

endmodule

`default_nettype wire

/* src/turn_model_select.sv */
`default_nettype none

// allowed output ports for XY and the turn-model / Duato algorithms
module turn_model_select (
    input  routing_pkg::route_mode_e mode,
    mesh_dir_if.consumer             dir,
    output routing_pkg::port_set_t   allowed
);
    import routing_pkg::*;

    port_e x_port;  // productive port in x
    port_e y_port;  // productive port in y

    assign x_port = dir.x_min ? WEST : EAST;
    assign y_port = dir.y_min ? NORTH : SOUTH;

    always_comb begin
        allowed = '0;
        if (dir.same_x && dir.same_y) begin
            allowed[LOCAL] = 1'b1;  // arrived
        end else if (dir.same_y) begin
            allowed[x_port] = 1'b1;  // straight along the row
        end else if (dir.same_x) begin
            allowed[y_port] = 1'b1;  // straight along the column
        end else begin
            // diagonal destination, turn restrictions apply
            case (mode)
                WEST_FIRST: begin
                    // all west hops first, adaptive once heading east
                    allowed[x_port] = 1'b1;
                    if (dir.x_plus) begin
                        allowed[y_port] = 1'b1;
                    end
                end
                NORTH_LAST: begin
                    allowed[x_port] = 1'b1;
                    allowed[SOUTH]  = dir.y_plus;  // north only at the end
                end
                NEGATIVE_FIRST: begin
                    if (dir.x_min) begin
                        allowed[WEST]  = 1'b1;
                        allowed[SOUTH] = dir.y_plus;
                    end else if (dir.y_min) begin
                        allowed[EAST]  = 1'b1;  // both hops positive
                        allowed[NORTH] = 1'b1;
                    end else begin
                        allowed[SOUTH] = 1'b1;  // no east-to-south turn
                    end
                end
                DUATO: begin
                    // fully adaptive minimal, either dimension
                    allowed[x_port] = 1'b1;
                    allowed[y_port] = 1'b1;
                end
                default: begin
                    // XY; odd-even result is taken from its own selector
                    allowed[x_port] = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/odd_even_select.sv */
`default_nettype none

`include "noc_defines.svh"

// odd-even turn model, router-side variant so column parity always applies
module odd_even_select (
    input  logic [`MESH_XW-1:0]    current_x,
    input  logic [`MESH_XW-1:0]    dest_x,
    mesh_dir_if.consumer           dir,
    output routing_pkg::port_set_t allowed
);
    import routing_pkg::*;

    logic [`MESH_XW-1:0] x_dist;  // only meaningful when east-bound
    port_e               y_port;

    assign x_dist = dest_x - current_x;
    assign y_port = dir.y_min ? NORTH : SOUTH;

    always_comb begin
        allowed = '0;
        if (dir.same_x && dir.same_y) begin
            allowed[LOCAL] = 1'b1;
        end else if (dir.same_y) begin
            allowed[dir.x_min ? WEST : EAST] = 1'b1;
        end else if (dir.same_x) begin
            allowed[y_port] = 1'b1;
        end else if (dir.x_plus) begin
            // east-bound: y turns only out of odd columns
            if (current_x[0]) begin
                allowed[y_port] = 1'b1;
            end
            // keep east unless it would land one hop short in an even column
            if (dest_x[0] || (x_dist != `MESH_XW'(1))) begin
                allowed[EAST] = 1'b1;
            end
        end else begin
            // west-bound, y turn allowed from even columns
            allowed[WEST] = 1'b1;
            if (!current_x[0]) begin
                allowed[y_port] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mesh_route_stage.sv */
`default_nettype none

`include "noc_defines.svh"

// registered route computation, one header in, one code out a cycle later
module mesh_route_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hdr_valid,   // one-cycle header strobe
    input  logic [2:0]          route_mode,
    input  logic [`MESH_XW-1:0] current_x,
    input  logic [`MESH_YW-1:0] current_y,
    input  logic [`MESH_XW-1:0] dest_x,
    input  logic [`MESH_YW-1:0] dest_y,
    output logic                route_valid, // answers hdr_valid
    output logic [3:0]          dest_code    // {dx, dy, use_x, use_y}
);
    import routing_pkg::*;

    route_mode_e mode;
    port_set_t   turn_allowed;  // XY / turn-model / Duato set
    port_set_t   oe_allowed;    // odd-even set
    port_set_t   sel_allowed;
    dest_code_t  next_code;

    assign mode = route_mode_e'(route_mode);

    mesh_dir_if dir_bus ();

    // single comparator shared by all algorithms
    mesh_dir u_dir (
        .current_x (current_x),
        .current_y (current_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .dir       (dir_bus)
    );

    turn_model_select u_turn (
        .mode    (mode),
        .dir     (dir_bus),
        .allowed (turn_allowed)
    );

    odd_even_select u_odd_even (
        .current_x (current_x),
        .dest_x    (dest_x),
        .dir       (dir_bus),
        .allowed   (oe_allowed)
    );

    // mode steering
    assign sel_allowed = (mode == ODD_EVEN) ? oe_allowed : turn_allowed;

    // pack the code, both allow bits low means local
    always_comb begin
        next_code.dx    = dir_bus.x_plus;
        next_code.dy    = dir_bus.y_min;   // north is smaller y
        next_code.use_x = sel_allowed[EAST] | sel_allowed[WEST];
        next_code.use_y = sel_allowed[NORTH] | sel_allowed[SOUTH];
    end

    // output register, code holds between headers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_valid <= 1'b0;
            dest_code   <= '0;
        end else begin
            route_valid <= hdr_valid;  // single-cycle pulse
            if (hdr_valid) begin
                dest_code <= next_code;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`default_nettype none

// free-running testbench clock, starts low
module tb_clk_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;  // half period per phase
    end

endmodule

`default_nettype wire

/* sim/mesh_route_tb.sv */
`default_nettype none

`include "noc_defines.svh"

// testbench for the registered route stage
module mesh_route_tb;
    localparam int wait_limit   = 8;     // cycles allowed for route_valid
    localparam int random_count = 200;
    localparam int max_lines    = 1000;  // guard on the file reader

    logic                clk;
    logic                rst_n;
    logic                hdr_valid;
    logic [2:0]          route_mode;
    logic [`MESH_XW-1:0] current_x;
    logic [`MESH_YW-1:0] current_y;
    logic [`MESH_XW-1:0] dest_x;
    logic [`MESH_YW-1:0] dest_y;
    logic                route_valid;
    logic [3:0]          dest_code;

    // scoreboard, at most one result in flight
    logic                pending;    // header sampled on the last rising edge
    logic [3:0]          exp_code;
    logic [3:0]          last_code;  // value dest_code must hold between headers
    int                  errors;
    int                  checks;
    logic [31:0]         rnd;
    logic [`MESH_XW-1:0] r_cx;
    logic [`MESH_YW-1:0] r_cy;
    logic [`MESH_XW-1:0] r_dx;
    logic [`MESH_YW-1:0] r_dy;

    tb_clk_gen #(.period(40)) u_clk (.clk(clk));

    mesh_route_stage u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .hdr_valid   (hdr_valid),
        .route_mode  (route_mode),
        .current_x   (current_x),
        .current_y   (current_y),
        .dest_x      (dest_x),
        .dest_y      (dest_y),
        .route_valid (route_valid),
        .dest_code   (dest_code)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;  // full-period 32-bit lcg
    endfunction

    // xy code straight from the routing rules
    function automatic logic [3:0] xy_code(input logic [`MESH_XW-1:0] cx,
                                           input logic [`MESH_YW-1:0] cy,
                                           input logic [`MESH_XW-1:0] dx,
                                           input logic [`MESH_YW-1:0] dy);
        logic go_east;
        logic go_north;
        logic x_differs;
        logic y_differs;
        go_east   = dx > cx;
        go_north  = dy < cy;  // north is the smaller y
        x_differs = dx != cx;
        y_differs = dy != cy;
        return {go_east, go_north, x_differs, !x_differs && y_differs};
    endfunction

    // outputs are stable at the falling edge
    task automatic check_outputs();
        checks++;
        if (pending) begin
            if (route_valid !== 1'b1) begin
                $display("CHECK FAILED route_valid: expected %h, actual %h at %0t",
                         1'b1, route_valid, $time);
                errors++;
            end
            if (dest_code !== exp_code) begin
                $display("CHECK FAILED dest_code: expected %h, actual %h at %0t",
                         exp_code, dest_code, $time);
                errors++;
            end
            last_code = exp_code;
        end else begin
            if (route_valid !== 1'b0) begin
                $display("CHECK FAILED route_valid: expected %h, actual %h at %0t",
                         1'b0, route_valid, $time);
                errors++;
            end
            if (dest_code !== last_code) begin  // must hold through a gap
                $display("CHECK FAILED dest_code: expected %h, actual %h at %0t",
                         last_code, dest_code, $time);
                errors++;
            end
        end
    endtask

    task automatic send_header(input logic [2:0]          mode,
                               input logic [`MESH_XW-1:0] cx,
                               input logic [`MESH_YW-1:0] cy,
                               input logic [`MESH_XW-1:0] dx,
                               input logic [`MESH_YW-1:0] dy,
                               input logic [3:0]          code);
        @(negedge clk);
        check_outputs();  // result of the previous cycle
        route_mode = mode;
        current_x  = cx;
        current_y  = cy;
        dest_x     = dx;
        dest_y     = dy;
        hdr_valid  = 1'b1;
        pending    = 1'b1;
        exp_code   = code;
    endtask

    task automatic send_idle();
        @(negedge clk);
        check_outputs();
        hdr_valid = 1'b0;
        current_x = ~current_x;  // new address, code must not follow
        dest_y    = ~dest_y;
        pending   = 1'b0;
    endtask

    task automatic draw_xy();
        rnd  = lcg_next(rnd);
        r_cx = rnd[16 +: `MESH_XW];  // upper bits, low lcg bits are weak
        r_cy = rnd[20 +: `MESH_YW];
        r_dx = rnd[24 +: `MESH_XW];
        r_dy = rnd[28 +: `MESH_YW];
    endtask

    // lone header, then poll for route_valid
    task automatic isolated_header();
        int   cycles;
        logic seen;
        draw_xy();
        send_header(3'd0, r_cx, r_cy, r_dx, r_dy, xy_code(r_cx, r_cy, r_dx, r_dy));
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
            hdr_valid = 1'b0;
            if (route_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        pending = 1'b0;
        checks++;
        if (!seen) begin
            $display("timeout, route_valid stayed low for %0d cycles", wait_limit);
            errors++;
        end else begin
            if (cycles != 1) begin
                $display("route_valid came %0d cycles after the header, not 1", cycles);
                errors++;
            end
            if (dest_code !== exp_code) begin
                $display("CHECK FAILED dest_code: expected %h, actual %h at %0t",
                         exp_code, dest_code, $time);
                errors++;
            end
        end
        last_code = exp_code;
    endtask

    // vectors applied back to back, one per cycle
    task automatic run_file_vectors();
        int                  fd;
        int                  got;
        int                  n;
        int                  lines;
        int                  vectors;
        logic [8*160-1:0]    line;
        logic [2:0]          v_mode;
        logic [`MESH_XW-1:0] v_cx;
        logic [`MESH_YW-1:0] v_cy;
        logic [`MESH_XW-1:0] v_dx;
        logic [`MESH_YW-1:0] v_dy;
        logic [3:0]          v_code;
        lines   = 0;
        vectors = 0;
        fd = $fopen("sim/route_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/route_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && lines < max_lines) begin
                lines++;
                line = '0;
                got  = $fgets(line, fd);
                if (got > 0) begin
                    // comment lines fail the first %h and are skipped
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                v_mode, v_cx, v_cy, v_dx, v_dy, v_code);
                    if (n == 6) begin
                        send_header(v_mode, v_cx, v_cy, v_dx, v_dy, v_code);
                        vectors++;
                    end
                end
            end
            $fclose(fd);
            if (vectors == 0) begin
                $display("stimulus file held no vectors");
                errors++;
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        hdr_valid  = 1'b0;
        route_mode = 3'd0;
        current_x  = '0;
        current_y  = '0;
        dest_x     = '0;
        dest_y     = '0;
        pending    = 1'b0;
        exp_code   = 4'h0;
        last_code  = 4'h0;  // reset value of dest_code
        errors     = 0;
        checks     = 0;
        rnd        = 32'haac672c2;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // quiet after reset, no header yet
        send_idle();
        send_idle();

        run_file_vectors();
        send_idle();  // collects the last file result
        send_idle();

        // burst of three, a gap, then a lone header
        repeat (3) begin
            draw_xy();
            send_header(3'd0, r_cx, r_cy, r_dx, r_dy, xy_code(r_cx, r_cy, r_dx, r_dy));
        end
        send_idle();
        send_idle();
        send_idle();
        isolated_header();
        send_idle();

        for (int i = 0; i < random_count; i++) begin
            draw_xy();
            send_header(3'd0, r_cx, r_cy, r_dx, r_dy, xy_code(r_cx, r_cy, r_dx, r_dy));
            if (rnd[2:0] == 3'd0) begin
                send_idle();  // occasional bubble
            end
        end
        send_idle();
        send_idle();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/route_stimulus.txt */
# columns: mode cur_x cur_y dest_x dest_y code, all hex
# code bits are dx dy use_x use_y, msb first
0 1 2 1 2 0
0 1 2 3 2 a
0 1 2 0 2 2
0 1 2 1 0 5
0 1 2 1 3 1
0 1 2 3 0 e
0 1 2 3 3 a
0 1 2 0 0 6
0 1 2 0 3 2
1 1 2 3 0 f
1 1 2 3 3 b
1 1 2 0 0 6
1 1 2 0 3 2
2 1 2 3 0 e
2 1 2 3 3 b
2 1 2 0 0 6
2 1 2 0 3 3
3 1 2 3 0 f
3 1 2 3 3 9
3 1 2 0 0 6
3 1 2 0 3 3
4 1 2 3 0 f
4 1 2 3 3 b
4 1 2 0 0 7
4 1 2 0 3 3
5 0 2 1 0 e
5 1 2 2 0 d
5 1 2 3 3 b
5 0 2 2 3 a
5 3 2 2 0 6
5 2 2 1 3 3
5 3 2 1 3 2
5 2 2 0 0 7
5 2 1 2 1 0
5 2 2 2 0 5

/* all.f */
+incdir+src
src/routing_pkg.sv
src/mesh_dir_if.sv
src/mesh_dir.sv
src/turn_model_select.sv
src/odd_even_select.sv
src/mesh_route_stage.sv
sim/tb_clk_gen.sv
sim/mesh_route_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, verdict taken from the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary -f all.f --top-module mesh_route_tb -o mesh_route_sim > build.log 2>&1 &&
    ./obj_dir/mesh_route_sim > sim.log 2>&1 &&
    cat sim.log &&
    ! grep -q "Simulation failed" sim.log ||
    { cat build.log sim.log 2>/dev/null; echo "run failed"; exit 1; }
